// ==== apuCore.f ====
logic/apuRegPkg.sv
logic/apuAudioPkg.sv
logic/channelWrite.sv
logic/registerDecoder.sv
logic/frameSequencer.sv
logic/pulseChannel.sv
logic/apuOutput.sv
logic/apuCore.sv
verification/apuChecker.sv
verification/apuCoreTb.sv

// ==== Makefile ====
# Verilator build and run of the pulse sound unit testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module apuCoreTb -Mdir obj_dir -f apuCore.f
	@out="$$(./obj_dir/VapuCoreTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== verification/apuCoreTb.sv ====
/* Testbench for the pulse sound unit with clock, reset,
   stimulus table, window loop and timeout */
`timescale 1ns/10ps
`default_nettype none

module apuCoreTb;

	localparam int QuarterCycles = 16;
	localparam int EntryCount = 8;

	localparam logic [2:0] KindReset = 3'd0;
	localparam logic [2:0] KindStatus = 3'd1;
	localparam logic [2:0] KindMix = 3'd2;
	localparam logic [2:0] KindLength = 3'd3;
	localparam logic [2:0] KindEnvDecay = 3'd4;
	localparam logic [2:0] KindEnvLoop = 3'd5;

	typedef struct {
		logic [3:0] volume;
		logic constant;
		logic loopHalt;
		logic [1:0] duty;
		apuAudioPkg::TimerPeriod period; // Zero means a random period
		logic [4:0] lengthIndex;
	} ChannelSetting;

	typedef struct {
		ChannelSetting pulse1;
		ChannelSetting pulse2;
		logic [1:0] enable;
		int window;
		logic [2:0] kind;
	} TestEntry;

	logic clk;
	logic reset;
	logic ce;
	logic write;
	apuRegPkg::RegAddr addr;
	logic [7:0] writeData;
	apuAudioPkg::MixedSample sample;
	logic [7:0] status;

	TestEntry tests [EntryCount];
	int seed;
	int cycleCount;
	int cycleLimit;
	int errorCount;
	logic windowActive;
	logic [2:0] curKind;
	int windowCycle;
	logic [1:0] curEnable;
	logic [3:0] curVolume1;
	logic [3:0] curVolume2;
	apuAudioPkg::TimerPeriod curPeriod1;
	apuAudioPkg::TimerPeriod curPeriod2;

	apuCore #(
		.QuarterFrameCycles (QuarterCycles)
	) uut (
		.clk       (clk),
		.reset     (reset),
		.ce        (ce),
		.write     (write),
		.addr      (addr),
		.writeData (writeData),
		.sample    (sample),
		.status    (status)
	);

	apuChecker #(
		.QuarterCycles (QuarterCycles)
	) outputCheck (
		.clk          (clk),
		.sample       (sample),
		.status       (status),
		.windowActive (windowActive),
		.checkKind    (curKind),
		.windowCycle  (windowCycle),
		.enableBits   (curEnable),
		.volume1      (curVolume1),
		.volume2      (curVolume2),
		.period1      (curPeriod1),
		.period2      (curPeriod2),
		.errorCount   (errorCount)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = !clk;
	end

	task automatic setChannel(output ChannelSetting s, input logic [3:0] volume,
			input logic constant, input logic loopHalt, input logic [1:0] duty,
			input int period, input logic [4:0] lengthIndex);
		s.volume = volume;
		s.constant = constant;
		s.loopHalt = loopHalt;
		s.duty = duty;
		s.lengthIndex = lengthIndex;
		if (period == 0)
			s.period = apuAudioPkg::TimerPeriod'(8 + ($unsigned($random(seed)) % 33));
		else
			s.period = apuAudioPkg::TimerPeriod'(period);
	endtask

	// Called 1 ns after an edge, returns 1 ns after the next one
	task automatic writeReg(input apuRegPkg::RegAddr a, input logic [7:0] d);
		write = 1'b1;
		addr = a;
		writeData = d;
		@(posedge clk);
		#1;
		write = 1'b0;
	endtask

	task automatic writeChannel(input apuRegPkg::RegAddr base, input ChannelSetting s);
		writeReg(base, {s.duty, s.loopHalt, s.constant, s.volume});
		writeReg(base + 5'd2, s.period[7:0]);
		writeReg(base + 5'd3, {s.lengthIndex, s.period[10:8]});
	endtask

	initial begin
		seed = 32'h0cd6_b6f8;
		// Settings: volume, constant, loop, duty, period, length index
		setChannel(tests[0].pulse1, 4'd0, 1'b1, 1'b0, 2'd2, 0, 5'd1);
		setChannel(tests[0].pulse2, 4'd0, 1'b1, 1'b0, 2'd2, 0, 5'd1);
		tests[0].enable = 2'b00;
		tests[0].window = 8;
		tests[0].kind = KindReset;
		setChannel(tests[1].pulse1, 4'd5, 1'b1, 1'b0, 2'd2, 0, 5'd1);
		setChannel(tests[1].pulse2, 4'd9, 1'b1, 1'b0, 2'd2, 0, 5'd1);
		tests[1].enable = 2'b11;
		tests[1].window = 20;
		tests[1].kind = KindStatus;
		tests[2] = tests[1];
		tests[2].enable = 2'b01; // Pulse 2 switched off
		setChannel(tests[3].pulse1, 4'd5, 1'b1, 1'b0, 2'd2, 0, 5'd1);
		setChannel(tests[3].pulse2, 4'd9, 1'b1, 1'b0, 2'd2, 0, 5'd1);
		tests[3].enable = 2'b11;
		tests[3].window = 400;
		tests[3].kind = KindMix;
		setChannel(tests[4].pulse1, 4'd6, 1'b1, 1'b0, 2'd2, 0, 5'd1);
		setChannel(tests[4].pulse2, 4'd7, 1'b1, 1'b0, 2'd2, 3, 5'd1); // Inaudible
		tests[4].enable = 2'b11;
		tests[4].window = 400;
		tests[4].kind = KindMix;
		setChannel(tests[5].pulse1, 4'd4, 1'b1, 1'b0, 2'd2, 0, 5'd0); // Loads 10
		setChannel(tests[5].pulse2, 4'd4, 1'b1, 1'b0, 2'd2, 0, 5'd1);
		tests[5].enable = 2'b01;
		tests[5].window = 400;
		tests[5].kind = KindLength;
		setChannel(tests[6].pulse1, 4'd0, 1'b0, 1'b0, 2'd3, 0, 5'd1);
		setChannel(tests[6].pulse2, 4'd0, 1'b0, 1'b0, 2'd3, 0, 5'd1);
		tests[6].enable = 2'b01;
		tests[6].window = 400;
		tests[6].kind = KindEnvDecay;
		tests[7] = tests[6];
		tests[7].pulse1.loopHalt = 1'b1;
		tests[7].kind = KindEnvLoop;

		cycleLimit = 200;
		for (int i = 0; i < EntryCount; i++)
			cycleLimit += tests[i].window;

		reset = 1'b1;
		ce = 1'b1;
		write = 1'b0;
		addr = '0;
		writeData = 8'd0;
		windowActive = 1'b0;
		curKind = KindReset;
		windowCycle = 0;
		curEnable = 2'b00;
		curVolume1 = 4'd0;
		curVolume2 = 4'd0;
		curPeriod1 = '0;
		curPeriod2 = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < EntryCount; i++) begin
			if (tests[i].kind != KindReset) begin
				writeReg(apuRegPkg::FrameAddr, 8'd0); // No frame clocks during the writes
				writeReg(apuRegPkg::EnableAddr, {6'd0, tests[i].enable});
				writeChannel(apuRegPkg::Pulse1Base, tests[i].pulse1);
				writeChannel(apuRegPkg::Pulse2Base, tests[i].pulse2);
				writeReg(apuRegPkg::FrameAddr, 8'd0);
			end
			curKind = tests[i].kind;
			curEnable = tests[i].enable;
			curVolume1 = tests[i].pulse1.volume;
			curVolume2 = tests[i].pulse2.volume;
			curPeriod1 = tests[i].pulse1.period;
			curPeriod2 = tests[i].pulse2.period;
			windowActive = 1'b1;
			for (int c = 0; c < tests[i].window; c++) begin
				windowCycle = c;
				@(posedge clk);
				#1;
			end
			windowActive = 1'b0;
		end

		repeat (2) @(posedge clk); // Checker closes the last window
		$display("Run finished with %0d errors", errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, the stimulus did not finish", cycleCount);
			$display("Checks failed");
			$finish;
		end
	end

	initial cycleCount = 0;

endmodule

`default_nettype wire

// ==== verification/apuChecker.sv ====
/* Checker for the pulse sound unit outputs, with expected values
   from the register rules and an error count */
`timescale 1ns/10ps
`default_nettype none

module apuChecker #(
	parameter int QuarterCycles = 16
) (
	input wire logic clk,
	input wire apuAudioPkg::MixedSample sample,
	input wire logic [7:0] status,
	input wire logic windowActive,
	input wire logic [2:0] checkKind,
	input wire logic signed [31:0] windowCycle,
	input wire logic [1:0] enableBits,
	input wire logic [3:0] volume1,
	input wire logic [3:0] volume2,
	input wire apuAudioPkg::TimerPeriod period1,
	input wire apuAudioPkg::TimerPeriod period2,
	output int errorCount
);

	localparam logic [2:0] KindReset = 3'd0;
	localparam logic [2:0] KindStatus = 3'd1;
	localparam logic [2:0] KindMix = 3'd2;
	localparam logic [2:0] KindLength = 3'd3;
	localparam logic [2:0] KindEnvDecay = 3'd4;
	localparam logic [2:0] KindEnvLoop = 3'd5;

	logic [4:0] level1;
	logic [4:0] level2;
	logic [4:0] target;
	logic wasActive;
	logic seenTarget; // Required value seen in this window

	// Short periods silence a channel
	assign level1 = (period1 < apuAudioPkg::MinAudiblePeriod) ? 5'd0 : {1'b0, volume1};
	assign level2 = (period2 < apuAudioPkg::MinAudiblePeriod) ? 5'd0 : {1'b0, volume2};
	assign target = level1 + level2;

	initial begin
		errorCount = 0;
		wasActive = 1'b0;
		seenTarget = 1'b0;
	end

	task automatic expectSample(input logic [4:0] expected);
		if (sample !== expected) begin
			errorCount++;
			$display("Error at %0t: sample expected %0d, actual %0d", $time, expected, sample);
		end
	endtask

	task automatic expectStatus(input logic [7:0] expected);
		if (status !== expected) begin
			errorCount++;
			$display("Error at %0t: status expected %0d, actual %0d", $time, expected, status);
		end
	endtask

	// Outputs settle between edges
	always @(negedge clk) begin
		if (windowActive) begin
			if (windowCycle == 0)
				seenTarget = 1'b0;
			case (checkKind)
				KindReset: begin
					expectSample(5'd0);
					expectStatus(8'd0);
				end
				KindStatus: expectStatus({6'd0, enableBits}); // Long lengths keep both bits
				KindMix: begin
					if (sample !== 5'd0 && sample !== level1 && sample !== level2
							&& sample !== target) begin
						errorCount++;
						$display("Error at %0t: sample expected one of 0, %0d, %0d, %0d, actual %0d",
							$time, level1, level2, target, sample);
					end
					if (sample == target)
						seenTarget = 1'b1;
				end
				KindLength: begin
					if (windowCycle <= 19 * QuarterCycles)
						expectStatus(8'd1);
					else if (windowCycle >= 21 * QuarterCycles)
						expectStatus(8'd0); // Ten half frames have passed
				end
				KindEnvDecay: if (windowCycle >= 17 * QuarterCycles) expectSample(5'd0);
				KindEnvLoop: begin
					if (windowCycle >= 17 * QuarterCycles && sample != 5'd0)
						seenTarget = 1'b1;
				end
				default: ;
			endcase
		end else if (wasActive && (checkKind == KindMix || checkKind == KindEnvLoop)
				&& !seenTarget) begin
			errorCount++;
			$display("Error at %0t: the expected nonzero sample never appeared in the window",
				$time);
		end
		wasActive = windowActive;
	end

endmodule

`default_nettype wire

// ==== logic/apuCore.sv ====
/* Top level of the pulse sound unit with decoder, frame sequencer,
   two pulse channels and the output stage */
`timescale 1ns/10ps
`default_nettype none

module apuCore #(
	parameter int QuarterFrameCycles = 3729
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic ce,
	input wire logic write,
	input wire apuRegPkg::RegAddr addr,
	input wire logic [7:0] writeData,
	output apuAudioPkg::MixedSample sample,
	output logic [7:0] status
);

	logic [1:0] enable;
	logic restart;
	logic quarterClock;
	logic halfClock;
	apuAudioPkg::ChannelSample pulse1Sample;
	apuAudioPkg::ChannelSample pulse2Sample;
	logic pulse1Active;
	logic pulse2Active;

	channelWrite pulse1Write ();
	channelWrite pulse2Write ();

	registerDecoder decoder (
		.clk       (clk),
		.reset     (reset),
		.write     (write),
		.addr      (addr),
		.writeData (writeData),
		.pulse1    (pulse1Write),
		.pulse2    (pulse2Write),
		.enable    (enable),
		.restart   (restart)
	);

	frameSequencer #(
		.QuarterFrameCycles (QuarterFrameCycles)
	) sequencer (
		.clk          (clk),
		.reset        (reset),
		.ce           (ce),
		.restart      (restart),
		.quarterClock (quarterClock),
		.halfClock    (halfClock)
	);

	pulseChannel pulse1 (
		.clk          (clk),
		.reset        (reset),
		.ce           (ce),
		.regs         (pulse1Write),
		.enable       (enable[0]),
		.quarterClock (quarterClock),
		.halfClock    (halfClock),
		.sample       (pulse1Sample),
		.lengthActive (pulse1Active)
	);

	pulseChannel pulse2 (
		.clk          (clk),
		.reset        (reset),
		.ce           (ce),
		.regs         (pulse2Write),
		.enable       (enable[1]),
		.quarterClock (quarterClock),
		.halfClock    (halfClock),
		.sample       (pulse2Sample),
		.lengthActive (pulse2Active)
	);

	apuOutput outputStage (
		.clk          (clk),
		.reset        (reset),
		.pulse1Sample (pulse1Sample),
		.pulse2Sample (pulse2Sample),
		.pulse1Active (pulse1Active),
		.pulse2Active (pulse2Active),
		.sample       (sample),
		.status       (status)
	);

endmodule

`default_nettype wire

// ==== logic/apuOutput.sv ====
/* Registered mix of the two pulse samples and the status byte */
`timescale 1ns/10ps
`default_nettype none

module apuOutput (
	input wire logic clk,
	input wire logic reset,
	input wire apuAudioPkg::ChannelSample pulse1Sample,
	input wire apuAudioPkg::ChannelSample pulse2Sample,
	input wire logic pulse1Active,
	input wire logic pulse2Active,
	output apuAudioPkg::MixedSample sample,
	output logic [7:0] status
);

	apuAudioPkg::MixedSample mixed;

	// Linear sum, one bit wider than a channel
	assign mixed = apuAudioPkg::MixedSample'(pulse1Sample)
		+ apuAudioPkg::MixedSample'(pulse2Sample);

	always_ff @(posedge clk) begin
		if (reset) begin
			sample <= '0;
		end else begin
			sample <= mixed;
		end
	end

	assign status = {6'b00_0000, pulse2Active, pulse1Active}; // Upper bits unused

endmodule

`default_nettype wire

// ==== logic/pulseChannel.sv ====
/* Pulse channel with period timer, duty sequencer, volume envelope
   and length counter */
`timescale 1ns/10ps
`default_nettype none

module pulseChannel (
	input wire logic clk,
	input wire logic reset,
	input wire logic ce,
	channelWrite.sink regs,
	input wire logic enable,
	input wire logic quarterClock,
	input wire logic halfClock,
	output apuAudioPkg::ChannelSample sample,
	output logic lengthActive
);

	// Register fields
	logic [1:0] duty;
	logic loopHalt;      // Envelope loop and length halt share one bit
	logic constantVolume;
	apuAudioPkg::EnvelopeLevel volume;
	apuAudioPkg::TimerPeriod period;

	apuAudioPkg::TimerPeriod timer;
	logic [2:0] dutyPos;
	apuAudioPkg::EnvelopeLevel envDivider;
	apuAudioPkg::EnvelopeLevel envLevel;
	logic envStart;
	apuRegPkg::LengthCount length;

	assign lengthActive = (length != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			duty <= 2'd0;
			loopHalt <= 1'b0;
			constantVolume <= 1'b0;
			volume <= '0;
			period <= '0;
			timer <= '0;
			dutyPos <= 3'd0;
			envDivider <= '0;
			envLevel <= '0;
			envStart <= 1'b0;
			length <= '0;
		end else begin
			if (ce) begin
				if (timer == '0) begin
					timer <= period;
					dutyPos <= dutyPos - 1'b1; // One duty step per reload
				end else begin
					timer <= timer - 1'b1;
				end
			end

			if (quarterClock) begin
				if (envStart) begin
					envStart <= 1'b0;
					envLevel <= apuAudioPkg::MaxEnvelope;
					envDivider <= volume;
				end else if (envDivider == '0) begin
					envDivider <= volume;
					if (envLevel != '0)
						envLevel <= envLevel - 1'b1;
					else if (loopHalt)
						envLevel <= apuAudioPkg::MaxEnvelope; // Looping envelope
				end else begin
					envDivider <= envDivider - 1'b1;
				end
			end

			if (halfClock && length != '0 && !loopHalt)
				length <= length - 1'b1;

			// Writes override the counting above
			if (regs.strobe) begin
				case (regs.regIndex)
					2'd0: begin
						duty <= regs.data[7:6];
						loopHalt <= regs.data[apuRegPkg::HaltBit];
						constantVolume <= regs.data[apuRegPkg::ConstantBit];
						volume <= regs.data[3:0];
					end
					2'd2: period[7:0] <= regs.data;
					2'd3: begin
						period[10:8] <= regs.data[2:0];
						length <= regs.lengthLoad;
						envStart <= 1'b1;
						dutyPos <= 3'd0;
					end
					default: ; // Sweep register has no unit behind it
				endcase
			end

			if (!enable)
				length <= '0; // Disabled channel stays silent
		end
	end

	always_comb begin
		if (length == '0 || period < apuAudioPkg::MinAudiblePeriod
				|| !apuAudioPkg::DutyPatterns[duty][dutyPos]) begin
			sample = '0;
		end else begin
			sample = constantVolume ? volume : envLevel;
		end
	end

	// The enable register keeps the length counter cleared
	assert property (@(posedge clk) disable iff (reset) !enable |=> length == '0);

endmodule

`default_nettype wire

// ==== logic/frameSequencer.sv ====
/* Frame sequencer that divides ce into quarter-frame and half-frame pulses */
`timescale 1ns/10ps
`default_nettype none

module frameSequencer #(
	parameter int QuarterFrameCycles = 3729
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic ce,
	input wire logic restart,
	output logic quarterClock,
	output logic halfClock
);

	localparam int CountWidth = $clog2(QuarterFrameCycles + 1);
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(QuarterFrameCycles - 1);

	logic [CountWidth-1:0] divider;
	logic halfPhase; // Set between the first and second quarter of a half frame

	assign quarterClock = ce && !restart && (divider == LastCount);
	assign halfClock = quarterClock && halfPhase;

	always_ff @(posedge clk) begin
		if (reset || restart) begin
			divider <= '0;
			halfPhase <= 1'b0;
		end else if (ce) begin
			if (divider == LastCount) begin
				divider <= '0;
				halfPhase <= !halfPhase;
			end else begin
				divider <= divider + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) halfClock |-> quarterClock);

endmodule

`default_nettype wire

// ==== logic/registerDecoder.sv ====
/* CPU write decoder with the channel enable register and the
   frame sequencer restart strobe */
`timescale 1ns/10ps
`default_nettype none

module registerDecoder (
	input wire logic clk,
	input wire logic reset,
	input wire logic write,
	input wire apuRegPkg::RegAddr addr,
	input wire logic [7:0] writeData,
	channelWrite.source pulse1,
	channelWrite.source pulse2,
	output logic [1:0] enable,
	output logic restart
);

	apuRegPkg::LengthIndex lengthIndex;
	apuRegPkg::LengthCount lengthLoad;

	assign lengthIndex = writeData[7:3];
	assign lengthLoad = {apuRegPkg::LengthTable[lengthIndex], 1'b0};

	// Each channel owns four registers
	assign pulse1.strobe = write && (addr[4:2] == apuRegPkg::Pulse1Base[4:2]);
	assign pulse1.regIndex = addr[1:0];
	assign pulse1.data = writeData;
	assign pulse1.lengthLoad = lengthLoad;

	assign pulse2.strobe = write && (addr[4:2] == apuRegPkg::Pulse2Base[4:2]);
	assign pulse2.regIndex = addr[1:0];
	assign pulse2.data = writeData;
	assign pulse2.lengthLoad = lengthLoad;

	assign restart = write && (addr == apuRegPkg::FrameAddr);

	always_ff @(posedge clk) begin
		if (reset) begin
			enable <= 2'b00;
		end else if (write && addr == apuRegPkg::EnableAddr) begin
			enable <= writeData[1:0]; // Bit 0 is pulse 1
		end
	end

	// A write lands in at most one channel
	assert property (@(posedge clk) disable iff (reset) !(pulse1.strobe && pulse2.strobe));

endmodule

`default_nettype wire

// ==== logic/channelWrite.sv ====
/* Register write path from the decoder to one pulse channel */
`timescale 1ns/10ps
`default_nettype none

interface channelWrite;

	logic strobe;                     // One cycle per write
	logic [1:0] regIndex;
	logic [7:0] data;
	apuRegPkg::LengthCount lengthLoad; // Table value for a register 3 write

	modport source (output strobe, output regIndex, output data, output lengthLoad);
	modport sink (input strobe, input regIndex, input data, input lengthLoad);

endinterface

`default_nettype wire

// ==== logic/apuAudioPkg.sv ====
/* Audio widths and types of the pulse channels and the duty patterns */
`default_nettype none

package apuAudioPkg;

	typedef logic [3:0] ChannelSample;
	typedef logic [4:0] MixedSample;   // Sum of two channels
	typedef logic [3:0] EnvelopeLevel;
	typedef logic [10:0] TimerPeriod;

	// Bit n is the output at duty step n
	localparam logic [7:0] DutyPatterns [4] = '{
		8'b0000_0001, // 12.5 %
		8'b0000_0011, // 25 %
		8'b0000_1111, // 50 %
		8'b1111_1100  // 25 % inverted
	};

	localparam TimerPeriod MinAudiblePeriod = 11'd8; // Shorter periods are ultrasonic
	localparam EnvelopeLevel MaxEnvelope = 4'd15;

endpackage

`default_nettype wire

// ==== logic/apuRegPkg.sv ====
/* Register map of the pulse part of the sound unit
   Addresses, field positions and the length-counter load table */
`default_nettype none

package apuRegPkg;

	typedef logic [4:0] RegAddr;     // Offset from the unit base
	typedef logic [4:0] LengthIndex; // Bits 7 to 3 of register 3
	typedef logic [7:0] LengthCount;

	localparam RegAddr Pulse1Base = 5'h00;
	localparam RegAddr Pulse2Base = 5'h04;
	localparam RegAddr EnableAddr = 5'h15; // Channel enable bits
	localparam RegAddr FrameAddr = 5'h17;  // Frame sequencer restart

	// Register 0 of a channel
	localparam int HaltBit = 5;     // Also the envelope loop bit
	localparam int ConstantBit = 4;

	// Half of the load value, shifted left by one on use
	localparam logic [6:0] LengthTable [32] = '{
		7'h05, 7'h7f, 7'h0a, 7'h01,
		7'h14, 7'h02, 7'h28, 7'h03,
		7'h50, 7'h04, 7'h1e, 7'h05,
		7'h07, 7'h06, 7'h0d, 7'h07,
		7'h06, 7'h08, 7'h0c, 7'h09,
		7'h18, 7'h0a, 7'h30, 7'h0b,
		7'h60, 7'h0c, 7'h24, 7'h0d,
		7'h08, 7'h0e, 7'h10, 7'h0f
	};

endpackage

`default_nettype wire
